// ==== build.f ====
source/isaPkg.sv
source/pipePkg.sv
source/instrDecoder.sv
source/executeStage.sv
source/resultStage.sv
source/coreDatapath.sv
tb/coreDatapathTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it; a $fatal gives a failing exit status
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert \
    --top-module coreDatapathTb \
    -f build.f \
    -o coreDatapathSim \
    && ./obj_dir/coreDatapathSim \
    || exit 1

// ==== source/coreDatapath.sv ====
`timescale 1ns/100ps

module coreDatapath #(
    parameter int memDepthLog2 = 6
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             instrValid,
    input  logic [31:0]      instr,
    input  logic [31:0]      pc,
    output pipePkg::retireT  retire
);

    import pipePkg::*;

    decodedOpT  decoded;
    execResultT executed;
    writebackT  writeback;

    instrDecoder i_instrDecoder (
        .clk        (clk),
        .reset      (reset),
        .instrValid (instrValid),
        .instr      (instr),
        .pc         (pc),
        .decoded    (decoded)
    );

    executeStage i_executeStage (
        .clk       (clk),
        .reset     (reset),
        .decoded   (decoded),
        .writeback (writeback),
        .executed  (executed)
    );

    resultStage #(
        .memDepthLog2 (memDepthLog2)
    ) i_resultStage (
        .clk       (clk),
        .reset     (reset),
        .executed  (executed),
        .writeback (writeback),
        .retire    (retire)
    );

endmodule

// ==== source/executeStage.sv ====
`timescale 1ns/100ps

module executeStage (
    input  logic               clk,
    input  logic               reset,
    input  pipePkg::decodedOpT decoded,
    input  pipePkg::writebackT writeback,
    output pipePkg::execResultT executed
);

    import isaPkg::*;
    import pipePkg::*;

    logic [xlen-1:0] regFile [32];
    logic            fwdA;
    logic            fwdB;
    logic [xlen-1:0] rs1Val;
    logic [xlen-1:0] rs2Val;
    logic [xlen-1:0] opB;
    logic [xlen-1:0] aluOut;
    logic            equal;
    logic            taken;
    logic [xlen-1:0] target;
    execResultT      execNext;

    // x0 is never written so it keeps its reset value
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regFile[i] <= '0;
            end
        end else if (writeback.write && writeback.rd != '0) begin
            regFile[writeback.rd] <= writeback.data;
        end
    end

    // result stage value bypasses the register file one slot behind
    assign fwdA   = writeback.write && (writeback.rd != '0) && (writeback.rd == decoded.rs1);
    assign fwdB   = writeback.write && (writeback.rd != '0) && (writeback.rd == decoded.rs2);
    assign rs1Val = fwdA ? writeback.data : regFile[decoded.rs1];
    assign rs2Val = fwdB ? writeback.data : regFile[decoded.rs2];

    assign opB = decoded.aluSrcImm ? decoded.imm : rs2Val;

    always_comb begin
        case (decoded.aluOp)
            aluSub:  aluOut = rs1Val - opB;
            aluAnd:  aluOut = rs1Val & opB;
            aluOr:   aluOut = rs1Val | opB;
            aluSlt:  aluOut = {{(xlen-1){1'b0}}, $signed(rs1Val) < $signed(opB)};
            default: aluOut = rs1Val + opB;
        endcase
    end

    assign equal = (rs1Val == rs2Val);
    assign taken = decoded.valid &&
                   (decoded.jump || (decoded.branch && (equal ^ decoded.branchNe)));
    // target only reported for control transfers
    assign target = (decoded.branch || decoded.jump) ? decoded.pc + decoded.imm : '0;

    always_comb begin
        execNext.valid     = decoded.valid;
        execNext.illegal   = decoded.illegal;
        execNext.rd        = decoded.rd;
        execNext.regWrite  = decoded.regWrite;
        execNext.memWrite  = decoded.memWrite;
        execNext.memRead   = decoded.memRead;
        execNext.resultSel = decoded.resultSel;
        execNext.aluResult = aluOut;
        execNext.storeData = rs2Val;
        execNext.imm       = decoded.imm;
        execNext.pcPlus4   = decoded.pc + 32'd4;
        execNext.taken     = taken;
        execNext.target    = target;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            executed.valid <= 1'b0;
        end else begin
            executed <= execNext;
        end
    end

    // x0 must read zero even when the result stage names it as rd
    assert property (@(posedge clk) disable iff (reset)
        decoded.valid && (decoded.rs1 == '0) |-> (rs1Val == '0));
    assert property (@(posedge clk) disable iff (reset)
        decoded.valid && (decoded.rs2 == '0) |-> (rs2Val == '0));

endmodule

// ==== source/instrDecoder.sv ====
`timescale 1ns/100ps

module instrDecoder (
    input  logic              clk,
    input  logic              reset,
    input  logic              instrValid,
    input  logic [31:0]       instr,
    input  logic [31:0]       pc,
    output pipePkg::decodedOpT decoded
);

    import isaPkg::*;
    import pipePkg::*;

    opcodeE          opcode;
    logic [2:0]      func3;
    logic            func7b5;
    logic            func7Bad;
    aluOpE           aluDec;
    logic            aluBad;
    immSelE          immSel;
    logic [xlen-1:0] immVal;
    decodedOpT       decNext;

    assign opcode  = opcodeE'(instr[6:0]);
    assign func3   = instr[14:12];
    assign func7b5 = instr[30];
    // only 0000000 and 0100000 are defined for register ops
    assign func7Bad = instr[31] || (instr[29:25] != 5'b0);

    // alu control from func3, func7[5] and the opcode
    always_comb begin
        aluDec = aluAdd;
        aluBad = 1'b0;
        case (func3)
            f3AddSub: aluDec = (opcode == opReg && func7b5) ? aluSub : aluAdd;
            f3Slt:    aluDec = aluSlt;
            f3Or:     aluDec = aluOr;
            f3And:    aluDec = aluAnd;
            default:  aluBad = 1'b1;
        endcase
    end

    always_comb begin
        case (opcode)
            opStore:  immSel = immS;
            opBranch: immSel = immB;
            opLui:    immSel = immU;
            opJal:    immSel = immJ;
            default:  immSel = immI;
        endcase
    end

    always_comb begin
        case (immSel)
            immS:    immVal = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            immB:    immVal = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            immU:    immVal = {instr[31:12], 12'b0};
            immJ:    immVal = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            default: immVal = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

    always_comb begin
        decNext           = '0;
        decNext.valid     = instrValid;
        decNext.rs1       = instr[19:15];
        decNext.rs2       = instr[24:20];
        decNext.rd        = instr[11:7];
        decNext.imm       = immVal;
        decNext.pc        = pc;
        decNext.aluOp     = aluAdd;
        decNext.resultSel = resAlu;
        case (opcode)
            opReg: begin
                decNext.regWrite = 1'b1;
                decNext.aluOp    = aluDec;
                decNext.illegal  = aluBad || func7Bad || (func7b5 && func3 != f3AddSub);
            end
            opImm: begin
                decNext.regWrite  = 1'b1;
                decNext.aluSrcImm = 1'b1;
                decNext.aluOp     = aluDec;
                decNext.illegal   = aluBad;
            end
            opLui: begin
                decNext.regWrite  = 1'b1;
                decNext.resultSel = resImm;
            end
            opLoad: begin
                decNext.regWrite  = 1'b1;
                decNext.memRead   = 1'b1;
                decNext.aluSrcImm = 1'b1;
                decNext.resultSel = resMem;
                decNext.illegal   = (func3 != f3Word);
            end
            opStore: begin
                decNext.memWrite  = 1'b1;
                decNext.aluSrcImm = 1'b1;
                decNext.illegal   = (func3 != f3Word);
            end
            opBranch: begin
                decNext.branch   = 1'b1;
                decNext.branchNe = (func3 == f3Bne);
                decNext.aluOp    = aluSub;
                decNext.illegal  = (func3 != f3Beq) && (func3 != f3Bne);
            end
            opJal: begin
                decNext.jump      = 1'b1;
                decNext.regWrite  = 1'b1;
                decNext.resultSel = resPcPlus4;
            end
            default: decNext.illegal = 1'b1;
        endcase
        // illegal stays valid but may not change any state
        if (decNext.illegal) begin
            decNext.regWrite = 1'b0;
            decNext.memWrite = 1'b0;
            decNext.memRead  = 1'b0;
            decNext.branch   = 1'b0;
            decNext.jump     = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            decoded.valid <= 1'b0;
        end else begin
            decoded <= decNext;
        end
    end

    // a valid record only follows a sampled instruction outside reset
    assert property (@(posedge clk) (reset || !instrValid) |=> !decoded.valid);

endmodule

// ==== source/isaPkg.sv ====
package isaPkg;

    localparam int xlen    = 32;
    localparam int regIdxW = 5;

    // major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        opReg    = 7'b0110011,
        opImm    = 7'b0010011,
        opLui    = 7'b0110111,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opBranch = 7'b1100011,
        opJal    = 7'b1101111
    } opcodeE;

    // ALU control encoding
    typedef enum logic [2:0] {
        aluAdd = 3'b000,
        aluSub = 3'b001,
        aluAnd = 3'b010,
        aluOr  = 3'b011,
        aluSlt = 3'b101
    } aluOpE;

    typedef enum logic [2:0] {
        immI,
        immS,
        immB,
        immU,
        immJ
    } immSelE;

    typedef enum logic [1:0] {
        resAlu     = 2'b00,
        resMem     = 2'b01,
        resPcPlus4 = 2'b10,
        resImm     = 2'b11
    } resultSelE;

    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;
    // word access for LW and SW
    localparam logic [2:0] f3Word   = 3'b010;
    localparam logic [2:0] f3Beq    = 3'b000;
    localparam logic [2:0] f3Bne    = 3'b001;

endpackage

// ==== source/pipePkg.sv ====
package pipePkg;

    import isaPkg::*;

    // decode to execute
    typedef struct packed {
        logic                valid;
        logic                illegal;
        logic [regIdxW-1:0]  rs1;
        logic [regIdxW-1:0]  rs2;
        logic [regIdxW-1:0]  rd;
        logic                regWrite;
        logic                memWrite;
        logic                memRead;
        logic                branch;
        logic                branchNe;
        logic                jump;
        logic                aluSrcImm;
        aluOpE               aluOp;
        resultSelE           resultSel;
        logic [xlen-1:0]     imm;
        logic [xlen-1:0]     pc;
    } decodedOpT;

    // execute to result
    typedef struct packed {
        logic                valid;
        logic                illegal;
        logic [regIdxW-1:0]  rd;
        logic                regWrite;
        logic                memWrite;
        logic                memRead;
        resultSelE           resultSel;
        logic [xlen-1:0]     aluResult;
        logic [xlen-1:0]     storeData;
        logic [xlen-1:0]     imm;
        logic [xlen-1:0]     pcPlus4;
        logic                taken;
        logic [xlen-1:0]     target;
    } execResultT;

    typedef struct packed {
        logic                write;
        logic [regIdxW-1:0]  rd;
        logic [xlen-1:0]     data;
    } writebackT;

    typedef struct packed {
        logic                valid;
        logic                illegal;
        logic                write;
        logic [regIdxW-1:0]  rd;
        logic [xlen-1:0]     data;
        logic                taken;
        logic [xlen-1:0]     target;
    } retireT;

endpackage

// ==== source/resultStage.sv ====
`timescale 1ns/100ps

module resultStage #(
    parameter int memDepthLog2 = 6
) (
    input  logic                clk,
    input  logic                reset,
    input  pipePkg::execResultT executed,
    output pipePkg::writebackT  writeback,
    output pipePkg::retireT     retire
);

    import isaPkg::*;
    import pipePkg::*;

    logic [xlen-1:0]         dataMem [2**memDepthLog2];
    logic [memDepthLog2-1:0] wordAddr;
    logic [xlen-1:0]         loadData;
    logic [xlen-1:0]         resultData;
    logic                    regWriteReal;
    retireT                  retireNext;

    assign wordAddr = executed.aluResult[memDepthLog2+1:2];
    // combinational read so a load can forward without a stall
    assign loadData = dataMem[wordAddr];

    always_ff @(posedge clk) begin
        if (executed.valid && executed.memWrite) begin
            dataMem[wordAddr] <= executed.storeData;
        end
    end

    always_comb begin
        case (executed.resultSel)
            resMem:     resultData = loadData;
            resPcPlus4: resultData = executed.pcPlus4;
            resImm:     resultData = executed.imm;
            default:    resultData = executed.aluResult;
        endcase
    end

    assign writeback.write = executed.valid && executed.regWrite;
    assign writeback.rd    = executed.rd;
    assign writeback.data  = resultData;

    assign regWriteReal = writeback.write && (executed.rd != '0);

    always_comb begin
        retireNext.valid   = executed.valid;
        retireNext.illegal = executed.illegal;
        retireNext.write   = writeback.write;
        retireNext.rd      = executed.rd;
        // data reads zero unless a real register is updated
        retireNext.data    = regWriteReal ? resultData : '0;
        retireNext.taken   = executed.taken;
        retireNext.target  = executed.target;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            retire.valid <= 1'b0;
        end else begin
            retire <= retireNext;
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        executed.valid && (executed.memRead || executed.memWrite)
        |-> (executed.aluResult[1:0] == 2'b00));

endmodule

// ==== tb/coreDatapathTb.sv ====
`timescale 1ns/100ps

module coreDatapathTb;

    import isaPkg::*;
    import pipePkg::*;

    localparam int          numEntries   = 34;
    localparam int          timeoutLimit = numEntries + 20;
    localparam logic [31:0] pcBase       = 32'h100;

    logic        clk;
    logic        reset;
    logic        instrValid;
    logic [31:0] instr;
    logic [31:0] pc;
    retireT      retire;

    string       names    [numEntries];
    logic        validTab [numEntries];
    logic [31:0] instrTab [numEntries];
    logic [31:0] pcTab    [numEntries];
    retireT      expTab   [numEntries];
    int          fillIdx    = 0;
    int          cycleCount = 0;

    coreDatapath #(
        .memDepthLog2 (6)
    ) i_coreDatapath (
        .clk        (clk),
        .reset      (reset),
        .instrValid (instrValid),
        .instr      (instr),
        .pc         (pc),
        .retire     (retire)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutLimit) begin
            $display("Checks failed");
            $fatal(1, "timeout: run did not finish within %0d cycles", timeoutLimit);
        end
    end

    // instruction encoders, straight from the RV32I formats
    function automatic logic [31:0] rType(input logic [6:0] f7, input int rs2, input int rs1,
                                          input logic [2:0] f3, input int rd);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], opReg};
    endfunction

    function automatic logic [31:0] iType(input int imm, input int rs1, input logic [2:0] f3,
                                          input int rd, input logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic logic [31:0] sType(input int imm, input int rs2, input int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3Word, imm[4:0], opStore};
    endfunction

    function automatic logic [31:0] bType(input int imm, input int rs2, input int rs1,
                                          input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], opBranch};
    endfunction

    function automatic logic [31:0] uType(input int imm, input int rd);
        return {imm[19:0], rd[4:0], opLui};
    endfunction

    function automatic logic [31:0] jType(input int imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], opJal};
    endfunction

    task automatic addEntry(input string name, input logic [31:0] word, input logic wr,
                            input int rd, input logic [31:0] data, input logic tk,
                            input logic [31:0] tgt, input logic ill);
        names[fillIdx]            = name;
        validTab[fillIdx]         = 1'b1;
        instrTab[fillIdx]         = word;
        pcTab[fillIdx]            = pcBase + 32'(fillIdx * 4);
        expTab[fillIdx]           = '0;
        expTab[fillIdx].valid     = 1'b1;
        expTab[fillIdx].illegal   = ill;
        expTab[fillIdx].write     = wr;
        expTab[fillIdx].rd        = rd[4:0];
        expTab[fillIdx].data      = data;
        expTab[fillIdx].taken     = tk;
        expTab[fillIdx].target    = tgt;
        fillIdx++;
    endtask

    task automatic addBubble(input string name, input logic [31:0] word);
        names[fillIdx]    = name;
        validTab[fillIdx] = 1'b0;
        instrTab[fillIdx] = word;
        pcTab[fillIdx]    = pcBase + 32'(fillIdx * 4);
        expTab[fillIdx]   = '0;
        fillIdx++;
    endtask

    // pc of entry i is 0x100 + 4*i, bubbles included
    task automatic buildTable();
        addEntry("addi x1", iType(5, 0, f3AddSub, 1, opImm), 1'b1, 1, 32'h5, 1'b0, 32'h0, 1'b0);
        addEntry("addi fwd", iType(-3, 1, f3AddSub, 2, opImm), 1'b1, 2, 32'h2, 1'b0, 32'h0, 1'b0);
        addEntry("add", rType(7'h00, 2, 1, f3AddSub, 3), 1'b1, 3, 32'h7, 1'b0, 32'h0, 1'b0);
        addEntry("sub neg", rType(7'h20, 3, 2, f3AddSub, 4), 1'b1, 4, 32'hFFFFFFFB,
                 1'b0, 32'h0, 1'b0);
        addEntry("slt neg", rType(7'h00, 1, 4, f3Slt, 5), 1'b1, 5, 32'h1, 1'b0, 32'h0, 1'b0);
        addEntry("slt pos", rType(7'h00, 4, 1, f3Slt, 6), 1'b1, 6, 32'h0, 1'b0, 32'h0, 1'b0);
        addEntry("and", rType(7'h00, 3, 1, f3And, 7), 1'b1, 7, 32'h5, 1'b0, 32'h0, 1'b0);
        addEntry("or", rType(7'h00, 2, 1, f3Or, 8), 1'b1, 8, 32'h7, 1'b0, 32'h0, 1'b0);
        addEntry("andi", iType(32'hF0, 4, f3And, 9, opImm), 1'b1, 9, 32'hF0, 1'b0, 32'h0, 1'b0);
        addEntry("ori neg", iType(-256, 1, f3Or, 10, opImm), 1'b1, 10, 32'hFFFFFF05,
                 1'b0, 32'h0, 1'b0);
        addEntry("slti neg", iType(-4, 4, f3Slt, 11, opImm), 1'b1, 11, 32'h1, 1'b0, 32'h0, 1'b0);
        addEntry("lui", uType(32'h12345, 12), 1'b1, 12, 32'h12345000, 1'b0, 32'h0, 1'b0);
        // the bubble carries a write to x12 that must never land
        addBubble("bubble a", iType(-1, 0, f3AddSub, 12, opImm));
        addEntry("addi past bubble", iType(32'h678, 12, f3AddSub, 13, opImm), 1'b1, 13,
                 32'h12345678, 1'b0, 32'h0, 1'b0);
        addEntry("addi fwd 2", iType(1, 13, f3AddSub, 14, opImm), 1'b1, 14, 32'h12345679,
                 1'b0, 32'h0, 1'b0);
        addEntry("add gap", rType(7'h00, 14, 13, f3AddSub, 15), 1'b1, 15, 32'h2468ACF1,
                 1'b0, 32'h0, 1'b0);
        addEntry("sw 0x8", sType(8, 14, 0), 1'b0, 8, 32'h0, 1'b0, 32'h0, 1'b0);
        addEntry("sw 0xf4", sType(4, 15, 9), 1'b0, 4, 32'h0, 1'b0, 32'h0, 1'b0);
        addEntry("lw 0x8", iType(8, 0, f3Word, 16, opLoad), 1'b1, 16, 32'h12345679,
                 1'b0, 32'h0, 1'b0);
        addEntry("lw 0xf4", iType(4, 9, f3Word, 17, opLoad), 1'b1, 17, 32'h2468ACF1,
                 1'b0, 32'h0, 1'b0);
        addEntry("add load fwd", rType(7'h00, 16, 17, f3AddSub, 18), 1'b1, 18, 32'h369D036A,
                 1'b0, 32'h0, 1'b0);
        addEntry("beq taken", bType(16, 2, 2, f3Beq), 1'b0, 0, 32'h0, 1'b1, 32'h164, 1'b0);
        addEntry("beq not taken", bType(-8, 2, 1, f3Beq), 1'b0, 0, 32'h0, 1'b0, 32'h150, 1'b0);
        addEntry("bne taken", bType(32, 2, 1, f3Bne), 1'b0, 0, 32'h0, 1'b1, 32'h17C, 1'b0);
        addEntry("bne not taken", bType(12, 3, 3, f3Bne), 1'b0, 0, 32'h0, 1'b0, 32'h16C, 1'b0);
        addEntry("jal", jType(32'h40, 19), 1'b1, 19, 32'h168, 1'b1, 32'h1A4, 1'b0);
        addEntry("addi x0", iType(7, 1, f3AddSub, 0, opImm), 1'b1, 0, 32'h0, 1'b0, 32'h0, 1'b0);
        addEntry("x0 fwd", rType(7'h00, 1, 0, f3AddSub, 20), 1'b1, 20, 32'h5, 1'b0, 32'h0, 1'b0);
        addEntry("x0 regfile", iType(0, 0, f3AddSub, 21, opImm), 1'b1, 21, 32'h0,
                 1'b0, 32'h0, 1'b0);
        addEntry("bad opcode", 32'h00A000FF, 1'b0, 1, 32'h0, 1'b0, 32'h0, 1'b1);
        addEntry("bad func7", rType(7'h01, 2, 1, f3AddSub, 22), 1'b0, 22, 32'h0,
                 1'b0, 32'h0, 1'b1);
        // x22 must still be zero after the illegal op
        addEntry("x22 unchanged", rType(7'h00, 1, 22, f3AddSub, 23), 1'b1, 23, 32'h5,
                 1'b0, 32'h0, 1'b0);
        addBubble("bubble b", 32'h0);
        addBubble("bubble c", 32'h0);
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("error %s expected %h actual %h", name, expected, actual);
            $display("Checks failed");
            $fatal(1, "retire value mismatch");
        end
    endtask

    task automatic checkRetire(input int idx);
        checkValue({names[idx], " valid"}, 32'(expTab[idx].valid), 32'(retire.valid));
        if (expTab[idx].valid) begin
            checkValue({names[idx], " illegal"}, 32'(expTab[idx].illegal), 32'(retire.illegal));
            checkValue({names[idx], " write"}, 32'(expTab[idx].write), 32'(retire.write));
            // rd field is only meaningful when a register is written
            if (expTab[idx].write) begin
                checkValue({names[idx], " rd"}, 32'(expTab[idx].rd), 32'(retire.rd));
            end
            checkValue({names[idx], " data"}, expTab[idx].data, retire.data);
            checkValue({names[idx], " taken"}, 32'(expTab[idx].taken), 32'(retire.taken));
            checkValue({names[idx], " target"}, expTab[idx].target, retire.target);
        end
    endtask

    initial begin
        reset      = 1'b1;
        instrValid = 1'b0;
        instr      = 32'h0;
        pc         = 32'h0;
        buildTable();
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        checkValue("after reset valid", 32'h0, 32'(retire.valid));
        // entry c retires three edges after it is driven, checked at the falling edge
        for (int c = 0; c < numEntries + 3; c++) begin
            @(posedge clk);
            if (c < numEntries) begin
                instrValid <= validTab[c];
                instr      <= instrTab[c];
                pc         <= pcTab[c];
            end else begin
                instrValid <= 1'b0;
            end
            @(negedge clk);
            if (c >= 3) begin
                checkRetire(c - 3);
            end else begin
                checkValue("pipeline empty valid", 32'h0, 32'(retire.valid));
            end
        end
        $display("All checks passed");
        $finish;
    end

endmodule
